// ==== Makefile ====
# Verilator build and run for the point doubling testbench

VERILATOR ?= verilator
TOP       ?= tb_ec_dbl
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_ec_dbl.sv ====
// Point doubling testbench
`default_nettype none

module tb_ec_dbl import ec_pkg::*; ();

  localparam int N_POINTS      = 12;
  localparam int CYC_PER_POINT = 300;  // Worst doubling is well under this
  localparam int RST_CYC       = 16;
  localparam int LIMIT         = N_POINTS * CYC_PER_POINT + RST_CYC;
  localparam int HOLD_CYC      = 20;

  logic        i_clk;
  logic        i_rst;
  fe_t         i_x, i_y, i_z;
  logic        i_val;
  logic        o_rdy;
  fe_t         o_x, o_y, o_z;
  logic        o_val;
  logic        i_rdy;
  int          n_err  = 0;
  int          cycles = 0;
  logic [31:0] rng    = 32'hdca1_9ffd;

  ec_dbl_top u_dut (
    .i_clk(i_clk), .i_rst(i_rst), .i_x(i_x), .i_y(i_y), .i_z(i_z), .i_val(i_val),
    .o_rdy(o_rdy), .o_x(o_x), .o_y(o_y), .o_z(o_z), .o_val(o_val), .i_rdy(i_rdy)
  );

  always #10 i_clk = ~i_clk;

  // Watchdog on the whole run
  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("ERROR: run went past %0d cycles, the DUT stopped responding", LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic fe_t next_fe();
    rng = xorshift32(rng);
    return fe_t'(rng % 32'(P_DEFAULT));  // Reduced below the prime
  endfunction

  function automatic fe_t nonzero_fe();
    fe_t v;
    v = next_fe();
    while (v == '0) v = next_fe();
    return v;
  endfunction

  // Fifteen doubling equations in plain 64-bit arithmetic
  function automatic void dbl_model(input fe_t x, input fe_t y, input fe_t z,
                                    output fe_t rx, output fe_t ry, output fe_t rz);
    logic [63:0] p, xv, yv, zv, a, b, c, d, e, xx, yy, zz;
    p  = 64'(P_DEFAULT);
    xv = 64'(x);
    yv = 64'(y);
    zv = 64'(z);
    a  = (yv * yv) % p;
    b  = (xv * a) % p;
    b  = (64'd4 * b) % p;
    c  = (a * a) % p;
    c  = (64'd8 * c) % p;
    d  = (xv * xv) % p;
    d  = (64'd3 * d) % p;
    xx = (d * d) % p;
    e  = (b + b) % p;
    xx = (xx + p - e) % p;  // Offset by p keeps it non-negative
    yy = (b + p - xx) % p;
    yy = (d * yy) % p;
    yy = (yy + p - c) % p;
    zz = (yv + yv) % p;
    zz = (zz * zv) % p;
    rx = fe_t'(xx);
    ry = fe_t'(yy);
    rz = fe_t'(zz);
  endfunction

  task automatic check_fe(input string name, input fe_t exp, input fe_t act);
    if (act !== exp) begin
      n_err++;
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic expect_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      n_err++;
      $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_point(input fe_t ex, input fe_t ey, input fe_t ez,
                             input fe_t ax, input fe_t ay, input fe_t az);
    check_fe("o_x", ex, ax);
    check_fe("o_y", ey, ay);
    check_fe("o_z", ez, az);
  endtask

  // Every drive happens 1 unit after the rising edge
  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic send_point(input fe_t x, input fe_t y, input fe_t z);
    while (!o_rdy) next_cycle();
    i_x   = x;
    i_y   = y;
    i_z   = z;
    i_val = 1'b1;
    next_cycle();  // Accepted on this edge
    i_val = 1'b0;
  endtask

  task automatic recv_point(output fe_t x, output fe_t y, output fe_t z);
    i_rdy = 1'b1;
    while (!o_val) next_cycle();
    x = o_x;
    y = o_y;
    z = o_z;
    next_cycle();  // Output taken
    i_rdy = 1'b0;
  endtask

  task automatic double_and_check(input fe_t x, input fe_t y, input fe_t z);
    fe_t ex, ey, ez, ax, ay, az;
    send_point(x, y, z);
    recv_point(ax, ay, az);
    if (z == '0) begin  // Infinity comes back as it went in
      ex = x;
      ey = y;
      ez = z;
    end else begin
      dbl_model(x, y, z, ex, ey, ez);
    end
    check_point(ex, ey, ez, ax, ay, az);
  endtask

  task automatic double_known_point();
    double_and_check(16'd3, 16'd5, 16'd1);
  endtask

  task automatic return_infinity();
    double_and_check(16'd1234, 16'd4321, 16'd0);
  endtask

  task automatic double_random_points();
    // Operands just below the prime
    double_and_check(P_DEFAULT - 16'd1, P_DEFAULT - 16'd2, P_DEFAULT - 16'd1);
    repeat (8) double_and_check(next_fe(), next_fe(), nonzero_fe());
  endtask

  task automatic hold_output();
    fe_t x, y, z, hx, hy, hz, ex, ey, ez, ax, ay, az;
    x = next_fe();
    y = next_fe();
    z = nonzero_fe();
    send_point(x, y, z);
    while (!o_val) next_cycle();  // i_rdy stays low
    hx = o_x;
    hy = o_y;
    hz = o_z;
    repeat (HOLD_CYC) begin
      next_cycle();
      expect_flag("o_val", 1'b1, o_val);
      expect_flag("o_rdy", 1'b0, o_rdy);
      check_fe("o_x", hx, o_x);
      check_fe("o_y", hy, o_y);
      check_fe("o_z", hz, o_z);
    end
    recv_point(ax, ay, az);
    dbl_model(x, y, z, ex, ey, ez);
    check_point(ex, ey, ez, ax, ay, az);
    double_and_check(next_fe(), next_fe(), nonzero_fe());  // Next point still goes through
  endtask

  task automatic reset_mid_run();
    send_point(16'd100, 16'd200, 16'd7);
    repeat (50) next_cycle();
    expect_flag("o_val", 1'b0, o_val);  // Doubling still under way
    i_rst = 1'b1;
    repeat (3) next_cycle();
    i_rst = 1'b0;
    expect_flag("o_val", 1'b0, o_val);
    expect_flag("o_rdy", 1'b1, o_rdy);
    double_and_check(next_fe(), next_fe(), nonzero_fe());
  endtask

  initial begin
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_val = 1'b0;
    i_rdy = 1'b0;
    i_x   = '0;
    i_y   = '0;
    i_z   = '0;
    repeat (RST_CYC) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    double_known_point();
    return_infinity();
    double_random_points();
    hold_output();
    reset_mid_run();
    $display("Doubling tests finished with %0d errors", n_err);
    if (n_err == 0) $display("TEST OK");
    else $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/ec_dbl_top.sv ====
// Point doubling subsystem
`default_nettype none

module ec_dbl_top import ec_pkg::*; #(
  parameter fe_t P_MOD = P_DEFAULT
) (
  input  wire logic i_clk,
  input  wire logic i_rst,
  input  wire fe_t  i_x,
  input  wire fe_t  i_y,
  input  wire fe_t  i_z,
  input  wire logic i_val,
  output logic      o_rdy,
  output fe_t       o_x,
  output fe_t       o_y,
  output fe_t       o_z,
  output logic      o_val,
  input  wire logic i_rdy
);

  // Issue side, sequencer to units
  fe_t     mul_a, mul_b, add_a, add_b, sub_a, sub_b;
  eq_tag_e mul_tag, add_tag, sub_tag;
  logic    mul_val, add_val, sub_val;
  logic    mul_rdy, add_rdy, sub_rdy;
  // Result side, units back to sequencer
  fe_t     mul_res, add_res, sub_res;
  eq_tag_e mul_rtag, add_rtag, sub_rtag;
  logic    mul_rval, add_rval, sub_rval;

  ec_point_dbl u_seq (
    .i_clk, .i_rst, .i_x, .i_y, .i_z, .i_val, .o_rdy, .o_x, .o_y, .o_z, .o_val, .i_rdy,
    .o_mul_a(mul_a), .o_mul_b(mul_b), .o_mul_tag(mul_tag), .o_mul_val(mul_val),
    .i_mul_rdy(mul_rdy), .i_mul_res(mul_res), .i_mul_tag(mul_rtag), .i_mul_val(mul_rval),
    .o_add_a(add_a), .o_add_b(add_b), .o_add_tag(add_tag), .o_add_val(add_val),
    .i_add_rdy(add_rdy), .i_add_res(add_res), .i_add_tag(add_rtag), .i_add_val(add_rval),
    .o_sub_a(sub_a), .o_sub_b(sub_b), .o_sub_tag(sub_tag), .o_sub_val(sub_val),
    .i_sub_rdy(sub_rdy), .i_sub_res(sub_res), .i_sub_tag(sub_rtag), .i_sub_val(sub_rval)
  );

  fp_mod_mul #(.P_MOD(P_MOD)) u_mul (
    .i_clk, .i_rst, .i_a(mul_a), .i_b(mul_b), .i_tag(mul_tag), .i_val(mul_val),
    .o_rdy(mul_rdy), .o_res(mul_res), .o_tag(mul_rtag), .o_val(mul_rval)
  );

  fp_mod_addsub #(.P_MOD(P_MOD), .OP(FP_ADD)) u_add (
    .i_clk, .i_rst, .i_a(add_a), .i_b(add_b), .i_tag(add_tag), .i_val(add_val),
    .o_rdy(add_rdy), .o_res(add_res), .o_tag(add_rtag), .o_val(add_rval)
  );

  fp_mod_addsub #(.P_MOD(P_MOD), .OP(FP_SUB)) u_sub (
    .i_clk, .i_rst, .i_a(sub_a), .i_b(sub_b), .i_tag(sub_tag), .i_val(sub_val),
    .o_rdy(sub_rdy), .o_res(sub_res), .o_tag(sub_rtag), .o_val(sub_rval)
  );

endmodule

`default_nettype wire

// ==== hw/ec_pkg.sv ====
// EC point doubling types
`default_nettype none

package ec_pkg;

  // Field element size
  localparam int FE_W = 16;

  typedef logic [FE_W-1:0] fe_t;

  // Largest 16-bit prime
  localparam fe_t P_DEFAULT = 16'd65521;

  // Doubling equations, encoding doubles as mask index
  typedef enum logic [3:0] {
    EQ_A  = 4'd0,   // A = y^2
    EQ_B  = 4'd1,   // B = x*A
    EQ_B4 = 4'd2,   // B = 4*B
    EQ_C  = 4'd3,   // C = A^2
    EQ_C8 = 4'd4,   // C = 8*C
    EQ_D  = 4'd5,   // D = x^2
    EQ_D3 = 4'd6,   // D = 3*D
    EQ_X  = 4'd7,   // X = D^2
    EQ_E  = 4'd8,   // E = B + B
    EQ_X2 = 4'd9,   // X = X - E
    EQ_Y  = 4'd10,  // Y = B - X
    EQ_Y2 = 4'd11,  // Y = D*Y
    EQ_Y3 = 4'd12,  // Y = Y - C
    EQ_Z  = 4'd13,  // Z = y + y
    EQ_Z2 = 4'd14   // Z = Z*z
  } eq_tag_e;

  // Number of equations per doubling
  localparam int EQ_NUM = 15;

  // Add/sub unit flavour
  typedef enum logic {
    FP_ADD = 1'b0,
    FP_SUB = 1'b1
  } fp_op_e;

endpackage

`default_nettype wire

// ==== hw/ec_point_dbl.sv ====
// Jacobian point doubling sequencer
`default_nettype none

module ec_point_dbl import ec_pkg::*; (
  input  wire logic    i_clk,
  input  wire logic    i_rst,
  // Input point
  input  wire fe_t     i_x,
  input  wire fe_t     i_y,
  input  wire fe_t     i_z,
  input  wire logic    i_val,
  output logic         o_rdy,
  // Doubled point
  output fe_t          o_x,
  output fe_t          o_y,
  output fe_t          o_z,
  output logic         o_val,
  input  wire logic    i_rdy,
  // Multiplier issue and result
  output fe_t          o_mul_a,
  output fe_t          o_mul_b,
  output eq_tag_e      o_mul_tag,
  output logic         o_mul_val,
  input  wire logic    i_mul_rdy,
  input  wire fe_t     i_mul_res,
  input  wire eq_tag_e i_mul_tag,
  input  wire logic    i_mul_val,
  // Adder issue and result
  output fe_t          o_add_a,
  output fe_t          o_add_b,
  output eq_tag_e      o_add_tag,
  output logic         o_add_val,
  input  wire logic    i_add_rdy,
  input  wire fe_t     i_add_res,
  input  wire eq_tag_e i_add_tag,
  input  wire logic    i_add_val,
  // Subtractor issue and result
  output fe_t          o_sub_a,
  output fe_t          o_sub_b,
  output eq_tag_e      o_sub_tag,
  output logic         o_sub_val,
  input  wire logic    i_sub_rdy,
  input  wire fe_t     i_sub_res,
  input  wire eq_tag_e i_sub_tag,
  input  wire logic    i_sub_val
);

  // Small multiples for a = 0 doubling
  localparam fe_t THREE = FE_W'(3);
  localparam fe_t FOUR  = FE_W'(4);
  localparam fe_t EIGHT = FE_W'(8);

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} state_e;

  state_e              state;
  logic [EQ_NUM-1:0]   eq_val;   // Result written back
  logic [EQ_NUM-1:0]   eq_iss;   // Sent to a unit
  fe_t                 x_l, y_l, z_l;  // Latched input point
  fe_t                 tmp_a, tmp_b, tmp_c, tmp_d, tmp_e;
  fe_t                 src_a [EQ_NUM];  // Operand a per equation
  fe_t                 src_b [EQ_NUM];
  eq_tag_e             mul_nxt, add_nxt, sub_nxt;
  logic                mul_go, add_go, sub_go;  // Some equation is ready
  logic                mul_fire, add_fire, sub_fire;
  logic                accept, run, is_inf;

  assign o_rdy  = (state == ST_IDLE);
  assign accept = o_rdy && i_val;
  assign run    = (state == ST_RUN);
  assign is_inf = (i_z == '0);  // z = 0 is infinity

  // Operand table
  always_comb begin
    src_a[EQ_A]  = y_l;    src_b[EQ_A]  = y_l;
    src_a[EQ_B]  = x_l;    src_b[EQ_B]  = tmp_a;
    src_a[EQ_B4] = tmp_b;  src_b[EQ_B4] = FOUR;
    src_a[EQ_C]  = tmp_a;  src_b[EQ_C]  = tmp_a;
    src_a[EQ_C8] = tmp_c;  src_b[EQ_C8] = EIGHT;
    src_a[EQ_D]  = x_l;    src_b[EQ_D]  = x_l;
    src_a[EQ_D3] = THREE;  src_b[EQ_D3] = tmp_d;
    src_a[EQ_X]  = tmp_d;  src_b[EQ_X]  = tmp_d;
    src_a[EQ_E]  = tmp_b;  src_b[EQ_E]  = tmp_b;
    src_a[EQ_X2] = o_x;    src_b[EQ_X2] = tmp_e;
    src_a[EQ_Y]  = tmp_b;  src_b[EQ_Y]  = o_x;
    src_a[EQ_Y2] = tmp_d;  src_b[EQ_Y2] = o_y;
    src_a[EQ_Y3] = o_y;    src_b[EQ_Y3] = tmp_c;
    src_a[EQ_Z]  = y_l;    src_b[EQ_Z]  = y_l;
    src_a[EQ_Z2] = o_z;    src_b[EQ_Z2] = z_l;
  end

  // Fixed priority pick per unit, first ready equation wins
  always_comb begin
    mul_go  = 1'b1;
    mul_nxt = EQ_A;
    if (!eq_iss[EQ_A]) mul_nxt = EQ_A;
    else if (eq_val[EQ_A] && !eq_iss[EQ_B]) mul_nxt = EQ_B;
    else if (eq_val[EQ_A] && !eq_iss[EQ_C]) mul_nxt = EQ_C;
    else if (!eq_iss[EQ_D]) mul_nxt = EQ_D;
    else if (eq_val[EQ_D] && !eq_iss[EQ_D3]) mul_nxt = EQ_D3;
    else if (eq_val[EQ_D3] && !eq_iss[EQ_X]) mul_nxt = EQ_X;
    else if (eq_val[EQ_Y] && eq_val[EQ_D3] && !eq_iss[EQ_Y2]) mul_nxt = EQ_Y2;
    else if (eq_val[EQ_Z] && !eq_iss[EQ_Z2]) mul_nxt = EQ_Z2;
    else if (eq_val[EQ_B] && !eq_iss[EQ_B4]) mul_nxt = EQ_B4;
    else if (eq_val[EQ_C] && !eq_iss[EQ_C8]) mul_nxt = EQ_C8;
    else mul_go = 1'b0;

    sub_go  = 1'b1;
    sub_nxt = EQ_X2;
    if (eq_val[EQ_E] && eq_val[EQ_X] && !eq_iss[EQ_X2]) sub_nxt = EQ_X2;
    else if (eq_val[EQ_X2] && eq_val[EQ_B4] && !eq_iss[EQ_Y]) sub_nxt = EQ_Y;
    else if (eq_val[EQ_C8] && eq_val[EQ_Y2] && !eq_iss[EQ_Y3]) sub_nxt = EQ_Y3;
    else sub_go = 1'b0;

    add_go  = 1'b1;
    add_nxt = EQ_E;
    if (eq_val[EQ_B4] && !eq_iss[EQ_E]) add_nxt = EQ_E;
    else if (!eq_iss[EQ_Z]) add_nxt = EQ_Z;
    else add_go = 1'b0;
  end

  // Multiplier drops ready once busy, so issue only into an idle unit
  assign mul_fire = run && mul_go && !o_mul_val && i_mul_rdy;
  assign add_fire = run && add_go && (!o_add_val || i_add_rdy);
  assign sub_fire = run && sub_go && (!o_sub_val || i_sub_rdy);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      o_val     <= 1'b0;
      eq_val    <= '0;
      eq_iss    <= '0;
      o_mul_val <= 1'b0;
      o_add_val <= 1'b0;
      o_sub_val <= 1'b0;
    end else begin
      if (o_mul_val && i_mul_rdy) o_mul_val <= 1'b0;  // Taken
      if (o_add_val && i_add_rdy) o_add_val <= 1'b0;
      if (o_sub_val && i_sub_rdy) o_sub_val <= 1'b0;
      if (mul_fire) o_mul_val <= 1'b1;
      if (add_fire) o_add_val <= 1'b1;
      if (sub_fire) o_sub_val <= 1'b1;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            eq_val <= '0;
            eq_iss <= '0;
            state  <= is_inf ? ST_DONE : ST_RUN;
            o_val  <= is_inf;  // Infinity bypasses the units
          end
        end
        ST_RUN: begin
          if (i_mul_val) eq_val[i_mul_tag] <= 1'b1;
          if (i_add_val) eq_val[i_add_tag] <= 1'b1;
          if (i_sub_val) eq_val[i_sub_tag] <= 1'b1;
          if (mul_fire) eq_iss[mul_nxt] <= 1'b1;
          if (add_fire) eq_iss[add_nxt] <= 1'b1;
          if (sub_fire) eq_iss[sub_nxt] <= 1'b1;
          if (&eq_val) begin
            o_val <= 1'b1;
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (i_rdy) begin  // Hold point until taken
            o_val <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Datapath, written back by tag
  always_ff @(posedge i_clk) begin
    if (accept) begin
      x_l <= i_x;
      y_l <= i_y;
      z_l <= i_z;
      if (is_inf) begin
        o_x <= i_x;
        o_y <= i_y;
        o_z <= i_z;
      end
    end
    if (mul_fire) begin
      o_mul_a   <= src_a[mul_nxt];
      o_mul_b   <= src_b[mul_nxt];
      o_mul_tag <= mul_nxt;
    end
    if (add_fire) begin
      o_add_a   <= src_a[add_nxt];
      o_add_b   <= src_b[add_nxt];
      o_add_tag <= add_nxt;
    end
    if (sub_fire) begin
      o_sub_a   <= src_a[sub_nxt];
      o_sub_b   <= src_b[sub_nxt];
      o_sub_tag <= sub_nxt;
    end
    if (run && i_mul_val) begin
      case (i_mul_tag)
        EQ_A:        tmp_a <= i_mul_res;
        EQ_B, EQ_B4: tmp_b <= i_mul_res;
        EQ_C, EQ_C8: tmp_c <= i_mul_res;
        EQ_D, EQ_D3: tmp_d <= i_mul_res;
        EQ_X:        o_x   <= i_mul_res;
        EQ_Y2:       o_y   <= i_mul_res;
        EQ_Z2:       o_z   <= i_mul_res;
        default: ;
      endcase
    end
    if (run && i_add_val) begin
      case (i_add_tag)
        EQ_E:    tmp_e <= i_add_res;
        EQ_Z:    o_z   <= i_add_res;
        default: ;
      endcase
    end
    if (run && i_sub_val) begin
      case (i_sub_tag)
        EQ_X2:       o_x <= i_sub_res;
        EQ_Y, EQ_Y3: o_y <= i_sub_res;
        default: ;
      endcase
    end
  end

  // Each unit only returns tags it was given
  a_mul_tag: assert property (@(posedge i_clk) disable iff (i_rst) i_mul_val |->
    i_mul_tag inside {EQ_A, EQ_B, EQ_B4, EQ_C, EQ_C8, EQ_D, EQ_D3, EQ_X, EQ_Y2, EQ_Z2});
  a_add_tag: assert property (@(posedge i_clk) disable iff (i_rst) i_add_val |->
    i_add_tag inside {EQ_E, EQ_Z});
  a_sub_tag: assert property (@(posedge i_clk) disable iff (i_rst) i_sub_val |->
    i_sub_tag inside {EQ_X2, EQ_Y, EQ_Y3});

endmodule

`default_nettype wire

// ==== hw/fp_mod_addsub.sv ====
// Modular adder or subtractor
`default_nettype none

module fp_mod_addsub import ec_pkg::*; #(
  parameter fe_t    P_MOD = P_DEFAULT,
  parameter fp_op_e OP    = FP_ADD
) (
  input  wire logic    i_clk,
  input  wire logic    i_rst,
  input  wire fe_t     i_a,
  input  wire fe_t     i_b,
  input  wire eq_tag_e i_tag,
  input  wire logic    i_val,
  output logic         o_rdy,
  output fe_t          o_res,
  output eq_tag_e      o_tag,
  output logic         o_val
);

  logic [FE_W:0] raw;  // Extra bit holds carry or borrow
  logic [FE_W:0] fix;

  always_comb begin
    if (OP == FP_ADD) begin
      raw = {1'b0, i_a} + {1'b0, i_b};
      fix = (raw >= {1'b0, P_MOD}) ? raw - {1'b0, P_MOD} : raw;  // At most one wrap
    end else begin
      raw = {1'b0, i_a} - {1'b0, i_b};
      fix = raw[FE_W] ? raw + {1'b0, P_MOD} : raw;  // Borrow, fold back into field
    end
  end

  assign o_rdy = 1'b1;  // Fully pipelined, never stalls

  always_ff @(posedge i_clk) begin
    if (i_rst) o_val <= 1'b0;
    else       o_val <= i_val && o_rdy;
  end

  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      o_res <= fix[FE_W-1:0];
      o_tag <= i_tag;
    end
  end

  // Single correction step only holds for reduced inputs
  a_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    i_val |-> (i_a < P_MOD) && (i_b < P_MOD));

endmodule

`default_nettype wire

// ==== hw/fp_mod_mul.sv ====
// Modular multiplier
`default_nettype none

module fp_mod_mul import ec_pkg::*; #(
  parameter fe_t P_MOD = P_DEFAULT
) (
  input  wire logic    i_clk,
  input  wire logic    i_rst,
  input  wire fe_t     i_a,
  input  wire fe_t     i_b,
  input  wire eq_tag_e i_tag,
  input  wire logic    i_val,
  output logic         o_rdy,
  output fe_t          o_res,
  output eq_tag_e      o_tag,
  output logic         o_val
);

  localparam int CNT_W = $clog2(FE_W);

  logic             busy;     // Step loop running
  logic [CNT_W-1:0] cnt;      // Steps left minus one
  fe_t              a_q;      // Addend
  fe_t              b_q;      // Multiplier bits, MSB first
  fe_t              acc;      // Partial product, always below P_MOD
  eq_tag_e          tag_q;
  logic [FE_W:0]    dbl_raw;
  logic [FE_W:0]    dbl_red;
  logic [FE_W:0]    add_raw;
  logic [FE_W:0]    add_red;

  // One double-and-add step
  always_comb begin
    dbl_raw = {acc, 1'b0};
    dbl_red = (dbl_raw >= {1'b0, P_MOD}) ? dbl_raw - {1'b0, P_MOD} : dbl_raw;
    add_raw = dbl_red + (b_q[FE_W-1] ? {1'b0, a_q} : '0);  // Add a when bit is set
    add_red = (add_raw >= {1'b0, P_MOD}) ? add_raw - {1'b0, P_MOD} : add_raw;
  end

  assign o_rdy = ~busy;  // One multiply in flight

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy  <= 1'b0;
      o_val <= 1'b0;
    end else begin
      o_val <= 1'b0;  // Result is a single pulse
      if (i_val && o_rdy) begin
        busy <= 1'b1;
      end else if (busy && cnt == '0) begin
        busy  <= 1'b0;
        o_val <= 1'b1;
      end
    end
  end

  // Operands and step datapath
  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      a_q   <= i_a;
      b_q   <= i_b;
      tag_q <= i_tag;
      acc   <= '0;
      cnt   <= CNT_W'(FE_W - 1);
    end else if (busy) begin
      acc <= add_red[FE_W-1:0];
      b_q <= b_q << 1;                // Next bit down
      cnt <= cnt - 1'b1;
      if (cnt == '0) begin
        o_res <= add_red[FE_W-1:0];   // Last step goes straight out
        o_tag <= tag_q;
      end
    end
  end

  // Issuer must wait for ready before raising valid
  a_no_overrun: assert property (@(posedge i_clk) disable iff (i_rst) i_val |-> o_rdy);

endmodule

`default_nettype wire

// ==== sources.f ====
hw/ec_pkg.sv
hw/fp_mod_mul.sv
hw/fp_mod_addsub.sv
hw/ec_point_dbl.sv
hw/ec_dbl_top.sv
dv/tb_ec_dbl.sv
